/* Bender.yml */
package:
  name: bsc

sources:
  - include_dirs:
      - common
    files:
      - common/isa_pkg.sv
      - common/ctrl_pkg.sv
      - state/bsc_count.sv
      - state/bsc_state.sv
      - verilog/bsc_decode.sv
      - datapath/bsc_alu.sv
      - datapath/bsc_regs.sv
      - verilog/bsc_top.sv
      - target: simulation
        include_dirs:
          - common
        files:
          - tb/tb_bsc.sv

/* common/bsc_cfg.svh */
`ifndef BSC_CFG_SVH
`define BSC_CFG_SVH

// width of the word addresses on both the instruction and the data bus
`define BSC_ADR_W 8

// word address of the first instruction fetched once reset is released
`define BSC_RST_PC 0

`endif

/* common/ctrl_pkg.sv */
package ctrl_pkg;

   // function of the serial ALU for the current pass
   // SUB also drives the signed compare, XOR the equality compare
   typedef enum logic [1:0] {
      ALU_ADD = 2'd0,
      ALU_SUB = 2'd1,
      ALU_AND = 2'd2,
      ALU_XOR = 2'd3
   } alu_op_e;

   // source of the bit shifted into rd during a writing pass
   // WS_CMP writes the latched condition into bit 0 and zero above it
   typedef enum logic [1:0] {
      WS_ALU = 2'd0,
      WS_IMM = 2'd1,
      WS_CMP = 2'd2
   } wsrc_e;

endpackage

/* common/isa_pkg.sv */
package isa_pkg;

   // register index, four general registers
   typedef logic [1:0] reg_idx_t;

   // operation codes in the top nibble of every instruction word
   typedef enum logic [3:0] {
      OP_ADD   = 4'd0,
      OP_SUB   = 4'd1,
      OP_AND   = 4'd2,
      OP_XOR   = 4'd3,
      OP_SLT   = 4'd4,
      OP_LI    = 4'd5,
      OP_BEQ   = 4'd6,
      OP_BNE   = 4'd7,
      OP_STORE = 4'd8
   } opcode_e;

   // register format, used by the ALU operations and by SLT
   typedef struct packed {
      opcode_e    opcode;
      reg_idx_t   rd;
      reg_idx_t   rs1;
      reg_idx_t   rs2;
      logic [21:0] rsvd;
   } r_fmt_t;

   // immediate format, used by LI, the branches and STORE
   // imm is a signed PC offset for branches and a word address for STORE
   typedef struct packed {
      opcode_e           opcode;
      reg_idx_t          ra;
      reg_idx_t          rb;
      logic [15:0]       rsvd;
      logic signed [7:0] imm;
   } b_fmt_t;

   // both views share the opcode field, so either one selects the format
   typedef union packed {
      r_fmt_t r;
      b_fmt_t b;
   } insn_u;

endpackage

/* datapath/bsc_alu.sv */
module bsc_alu (
   input  logic              i_clk,
   input  logic              i_rst,
   input  logic              i_cnt_en,
   input  logic              i_cnt0,
   input  logic              i_cnt_last,
   input  logic              i_init,
   input  ctrl_pkg::alu_op_e i_alu_op,
   input  logic              i_op_a,
   input  logic              i_op_b,
   output logic              o_res,
   output logic              o_cmp
);

   logic sub;
   logic op_b_eff;
   logic carry_q;
   logic carry_in;
   logic sum;
   logic carry_out;
   logic ne_acc;
   logic ne_bit;
   logic lt;

   // subtract is a + ~b + 1, the +1 comes from the carry preset on bit 0
   assign sub      = (i_alu_op == ctrl_pkg::ALU_SUB);
   assign op_b_eff = i_op_b ^ sub;
   assign carry_in = i_cnt0 ? sub : carry_q;

   assign sum       = i_op_a ^ op_b_eff ^ carry_in;
   assign carry_out = (i_op_a & op_b_eff) | (carry_in & (i_op_a ^ op_b_eff));

   always_comb begin
      case (i_alu_op)
         ctrl_pkg::ALU_AND: o_res = i_op_a & i_op_b;
         ctrl_pkg::ALU_XOR: o_res = i_op_a ^ i_op_b;
         default:           o_res = sum;
      endcase
   end

   // any differing bit so far, including the current one
   assign ne_bit = (ne_acc & !i_cnt0) | (i_op_a ^ i_op_b);

   // signed less-than on the sign bits of the last cycle
   // with different signs a is lower when it is negative,
   // with equal signs a - b borrows when the final carry is clear
   assign lt = (i_op_a ^ i_op_b) ? i_op_a : !carry_out;

   always_ff @(posedge i_clk) begin
      if (i_rst) begin
         carry_q <= 1'b0;
         ne_acc  <= 1'b0;
         o_cmp   <= 1'b0;
      end else begin
         if (i_cnt_en) begin
            carry_q <= carry_out;
         end
         if (i_cnt_en & i_init) begin
            ne_acc <= ne_bit;
         end
         // SLT keeps the signed compare, branches the not-equal flag
         // the result then holds through the writing pass
         if (i_cnt_last & i_init) begin
            o_cmp <= sub ? lt : ne_bit;
         end
      end
   end

endmodule

/* datapath/bsc_regs.sv */
`include "bsc_cfg.svh"

module bsc_regs (
   input  logic                  i_clk,
   input  logic                  i_rst,
   input  logic                  i_cnt_en,
   input  logic                  i_cnt0,
   input  logic                  i_init,
   input  logic                  i_rd_we,
   input  isa_pkg::reg_idx_t     i_rd,
   input  isa_pkg::reg_idx_t     i_rs1,
   input  isa_pkg::reg_idx_t     i_rs2,
   input  ctrl_pkg::wsrc_e       i_wsrc,
   input  logic [7:0]            i_imm,
   input  logic                  i_br_op,
   input  logic                  i_br_ne,
   input  logic                  i_cmp,
   input  logic                  i_alu_res,
   output logic                  o_op_a,
   output logic                  o_op_b,
   output logic [`BSC_ADR_W-1:0] o_ibus_adr,
   output logic [31:0]           o_dbus_dat
);

   localparam int ADR_W = `BSC_ADR_W;

   // every register rotates right once per counted cycle
   // so bit i of an operand sits in bit 0 on counted cycle i
   logic [31:0] rf [4];
   logic [31:0] pc;
   // immediate shifted right with sign fill, bit 0 is the current immediate bit
   logic [7:0]  imm_sr;
   logic        wbit;
   logic        taken;
   logic        pc_add;
   logic        pc_cin;
   logic        pc_sum;
   logic        pc_cout;
   logic        pc_c;

   assign o_op_a = rf[i_rs1][0];
   assign o_op_b = rf[i_rs2][0];

   // parallel taps, only meaningful while the registers stand still
   assign o_dbus_dat = rf[i_rs2];
   assign o_ibus_adr = pc[ADR_W-1:0];

   // bit that enters the top of rd on a writing pass
   always_comb begin
      case (i_wsrc)
         ctrl_pkg::WS_IMM: wbit = imm_sr[0];
         ctrl_pkg::WS_CMP: wbit = i_cnt0 & i_cmp;
         default:          wbit = i_alu_res;
      endcase
   end

   // BEQ branches when the not-equal flag is clear and BNE when it is set
   assign taken = i_br_op & (i_cmp == i_br_ne);

   // serial PC adder, the addend is the immediate on a taken branch and 1 otherwise
   assign pc_add  = taken ? imm_sr[0] : i_cnt0;
   assign pc_cin  = i_cnt0 ? 1'b0 : pc_c;
   assign pc_sum  = pc[0] ^ pc_add ^ pc_cin;
   assign pc_cout = (pc[0] & pc_add) | (pc_cin & (pc[0] ^ pc_add));

   always_ff @(posedge i_clk) begin
      if (i_rst) begin
         for (int i = 0; i < 4; i++) begin
            rf[i] <= '0;
         end
         pc     <= 32'(`BSC_RST_PC);
         imm_sr <= '0;
         pc_c   <= 1'b0;
      end else if (i_cnt_en) begin
         // the first pass of a two-stage op only reads, rd keeps rotating
         for (int i = 0; i < 4; i++) begin
            if (!i_init && i_rd_we && (i_rd == 2'(i))) begin
               rf[i] <= {wbit, rf[i][31:1]};
            end else begin
               rf[i] <= {rf[i][0], rf[i][31:1]};
            end
         end
         imm_sr <= {imm_sr[7], imm_sr[7:1]};
         // the PC only moves in the final pass
         if (!i_init) begin
            pc   <= {pc_sum, pc[31:1]};
            pc_c <= pc_cout;
         end
      end else begin
         // reloaded between passes so every pass starts at immediate bit 0
         imm_sr <= i_imm;
      end
   end

endmodule

/* project.f */
+incdir+common
common/isa_pkg.sv
common/ctrl_pkg.sv
state/bsc_count.sv
state/bsc_state.sv
verilog/bsc_decode.sv
datapath/bsc_alu.sv
datapath/bsc_regs.sv
verilog/bsc_top.sv
tb/tb_bsc.sv

/* state/bsc_count.sv */
module bsc_count (
   input  logic i_clk,
   input  logic i_rst,
   input  logic i_start_pass,
   output logic o_cnt_en,
   output logic o_cnt0,
   output logic o_cnt_last,
   output logic o_cnt_done
);

   // bit position is group * 4 + one-hot position in the ring
   logic [3:0] cnt_r;
   logic [2:0] cnt_grp;

   assign o_cnt0     = o_cnt_en & (cnt_grp == 3'd0) & cnt_r[0];
   assign o_cnt_last = o_cnt_en & (cnt_grp == 3'd7) & cnt_r[3];

   always_ff @(posedge i_clk) begin
      if (i_rst) begin
         o_cnt_en   <= 1'b0;
         o_cnt_done <= 1'b0;
         cnt_r      <= 4'b0001;
         cnt_grp    <= 3'd0;
      end else begin
         o_cnt_done <= o_cnt_last;
         if (i_start_pass) begin
            o_cnt_en <= 1'b1;
         end
         // the pass ends as done is raised, so done sees cnt_en low
         if (o_cnt_last) begin
            o_cnt_en <= 1'b0;
         end
         // after 32 steps ring and group are back at bit 0 for the next pass
         if (o_cnt_en) begin
            cnt_r   <= {cnt_r[2:0], cnt_r[3]};
            cnt_grp <= cnt_grp + {2'd0, cnt_r[3]};
         end
      end
   end

endmodule

/* state/bsc_state.sv */
module bsc_state (
   input  logic i_clk,
   input  logic i_rst,
   input  logic i_ibus_ack,
   input  logic i_dbus_ack,
   input  logic i_two_stage,
   input  logic i_mem_op,
   input  logic i_cnt_done,
   output logic o_ibus_cyc,
   output logic o_ibus_stb,
   output logic o_dbus_cyc,
   output logic o_dbus_stb,
   output logic o_start_pass,
   output logic o_init
);

   // FETCH   waits for the instruction word
   // MEM     holds the data bus write of a STORE
   // PASS1   first pass of a two-stage instruction, no writes
   // GAP     single start cycle in front of the final pass
   // PASS2   final pass, writes rd and moves the PC
   typedef enum logic [2:0] {
      FETCH = 3'd0,
      MEM   = 3'd1,
      PASS1 = 3'd2,
      GAP   = 3'd3,
      PASS2 = 3'd4
   } state_e;

   state_e state;
   logic   ibus_cyc;
   logic   fetch_ack;

   assign fetch_ack = ibus_cyc & i_ibus_ack;

   // cyc and stb always move together on both buses
   assign o_ibus_cyc = ibus_cyc;
   assign o_ibus_stb = ibus_cyc;
   assign o_dbus_cyc = (state == MEM);
   assign o_dbus_stb = (state == MEM);

   assign o_init = (state == PASS1);

   // a two-stage instruction starts its compare pass right on the fetch ack,
   // every final pass is started from its GAP cycle
   // for a two-stage op GAP follows the cnt_done cycle of the first pass
   assign o_start_pass = (state == GAP) | (fetch_ack & i_two_stage & !i_mem_op);

   always_ff @(posedge i_clk) begin
      if (i_rst) begin
         state    <= FETCH;
         ibus_cyc <= 1'b0;
      end else begin
         case (state)
            FETCH: begin
               // cyc is raised on the first cycle out of reset and stays up
               // until the slave acks, back-pressure just holds it here
               if (fetch_ack) begin
                  ibus_cyc <= 1'b0;
                  if (i_mem_op) begin
                     state <= MEM;
                  end else if (i_two_stage) begin
                     state <= PASS1;
                  end else begin
                     state <= GAP;
                  end
               end else begin
                  ibus_cyc <= 1'b1;
               end
            end
            MEM: begin
               if (i_dbus_ack) begin
                  state <= GAP;
               end
            end
            PASS1: begin
               // cmp is latched by now, go straight into the final pass start
               if (i_cnt_done) begin
                  state <= GAP;
               end
            end
            GAP: begin
               state <= PASS2;
            end
            PASS2: begin
               // the PC holds its new value here, so the next fetch opens at once
               if (i_cnt_done) begin
                  state    <= FETCH;
                  ibus_cyc <= 1'b1;
               end
            end
            default: begin
               state <= FETCH;
            end
         endcase
      end
   end

endmodule

/* tb/tb_bsc.sv */
`include "bsc_cfg.svh"

module tb_bsc;

   localparam int ADR_W  = `BSC_ADR_W;
   localparam int RST_PC = `BSC_RST_PC;
   // worst two-stage latency plus a fetch and a data ack each held back by the slaves
   localparam int CYC_PER_INSN = 67 + 2 * 4;

   logic             clk;
   logic             rst;
   logic             ibus_cyc;
   logic             ibus_stb;
   logic [ADR_W-1:0] ibus_adr;
   logic [31:0]      ibus_dat;
   logic             ibus_ack;
   logic             dbus_cyc;
   logic             dbus_stb;
   logic [ADR_W-1:0] dbus_adr;
   logic [31:0]      dbus_dat;
   logic             dbus_ack;

   // instruction memory and the lists the reference model fills
   logic [31:0]      imem [0:(1<<ADR_W)-1];
   int               prog_len = 0;
   logic [ADR_W-1:0] exp_fetch [$];
   logic [ADR_W-1:0] exp_st_adr [$];
   logic [31:0]      exp_st_dat [$];

   integer           seed;
   int               val_err = 0;
   int               other_err = 0;
   int               fetch_idx = 0;
   int               store_idx = 0;
   int               cycles = 0;
   int               limit;
   logic             halted = 1'b0;

   // slave wait state and master hold tracking per bus
   int               ibus_delay;
   int               dbus_delay;
   logic             ibus_wait = 1'b0;
   logic             dbus_wait = 1'b0;
   logic             ibus_open = 1'b0;
   logic             dbus_open = 1'b0;
   logic [ADR_W-1:0] ibus_adr_hold;
   logic [ADR_W-1:0] dbus_adr_hold;
   logic [31:0]      dbus_dat_hold;

   bsc_top u_dut (
      .i_clk      (clk),
      .i_rst      (rst),
      .o_ibus_cyc (ibus_cyc),
      .o_ibus_stb (ibus_stb),
      .o_ibus_adr (ibus_adr),
      .i_ibus_dat (ibus_dat),
      .i_ibus_ack (ibus_ack),
      .o_dbus_cyc (dbus_cyc),
      .o_dbus_stb (dbus_stb),
      .o_dbus_adr (dbus_adr),
      .o_dbus_dat (dbus_dat),
      .i_dbus_ack (dbus_ack)
   );

   initial begin
      clk = 1'b0;
      forever #20 clk = ~clk;
   end

   task automatic check_value(input logic [31:0] got, input logic [31:0] exp,
                              input string what);
      if (got !== exp) begin
         val_err = val_err + 1;
         $display("Error at %0t: %s, got %h expected %h", $time, what, got, exp);
      end
   endtask

   // X on the address counts as neither inside nor outside the program
   function automatic logic prog_hit(input logic [ADR_W-1:0] adr);
      if (^adr === 1'bx) begin
         return 1'bx;
      end
      return (int'(adr) >= RST_PC) && (int'(adr) < RST_PC + prog_len);
   endfunction

   function automatic logic [31:0] reg_insn(input isa_pkg::opcode_e op,
         input isa_pkg::reg_idx_t rd, input isa_pkg::reg_idx_t rs1,
         input isa_pkg::reg_idx_t rs2);
      isa_pkg::insn_u u;
      u          = '0;
      u.r.opcode = op;
      u.r.rd     = rd;
      u.r.rs1    = rs1;
      u.r.rs2    = rs2;
      return u;
   endfunction

   function automatic logic [31:0] imm_insn(input isa_pkg::opcode_e op,
         input isa_pkg::reg_idx_t ra, input isa_pkg::reg_idx_t rb, input logic [7:0] imm);
      isa_pkg::insn_u u;
      u          = '0;
      u.b.opcode = op;
      u.b.ra     = ra;
      u.b.rb     = rb;
      u.b.imm    = imm;
      return u;
   endfunction

   task automatic place(input logic [31:0] w);
      imem[RST_PC + prog_len] = w;
      prog_len = prog_len + 1;
   endtask

   task automatic build_program();
      logic [7:0] imm_a;
      logic [7:0] imm_b;
      imm_a = $random(seed);
      imm_b = $random(seed);
      // unused words carry an undefined opcode and their own address
      for (int i = 0; i < (1 << ADR_W); i++) begin
         imem[i] = 32'hF000_0000 | i;
      end
      // single-pass ops on random immediates, each result stored
      place(imm_insn(isa_pkg::OP_LI, 2'd0, 2'd0, imm_a));
      place(imm_insn(isa_pkg::OP_LI, 2'd1, 2'd0, imm_b));
      place(reg_insn(isa_pkg::OP_ADD, 2'd2, 2'd0, 2'd1));
      place(imm_insn(isa_pkg::OP_STORE, 2'd0, 2'd2, 8'h80));
      place(reg_insn(isa_pkg::OP_SUB, 2'd2, 2'd0, 2'd1));
      place(imm_insn(isa_pkg::OP_STORE, 2'd0, 2'd2, 8'h81));
      place(reg_insn(isa_pkg::OP_AND, 2'd2, 2'd0, 2'd1));
      place(imm_insn(isa_pkg::OP_STORE, 2'd0, 2'd2, 8'h82));
      place(reg_insn(isa_pkg::OP_XOR, 2'd3, 2'd0, 2'd1));
      place(imm_insn(isa_pkg::OP_STORE, 2'd0, 2'd3, 8'h83));
      place(reg_insn(isa_pkg::OP_SUB, 2'd3, 2'd3, 2'd2));
      place(reg_insn(isa_pkg::OP_ADD, 2'd3, 2'd3, 2'd3));
      place(imm_insn(isa_pkg::OP_STORE, 2'd0, 2'd3, 8'h84));
      // signed compares on random, equal and sign-differing pairs
      place(reg_insn(isa_pkg::OP_SLT, 2'd2, 2'd0, 2'd1));
      place(imm_insn(isa_pkg::OP_STORE, 2'd0, 2'd2, 8'h85));
      place(reg_insn(isa_pkg::OP_SLT, 2'd2, 2'd1, 2'd0));
      place(imm_insn(isa_pkg::OP_STORE, 2'd0, 2'd2, 8'h86));
      place(reg_insn(isa_pkg::OP_SLT, 2'd2, 2'd0, 2'd0));
      place(imm_insn(isa_pkg::OP_STORE, 2'd0, 2'd2, 8'h87));
      place(imm_insn(isa_pkg::OP_LI, 2'd2, 2'd0, 8'h80));
      place(imm_insn(isa_pkg::OP_LI, 2'd3, 2'd0, 8'h7F));
      place(reg_insn(isa_pkg::OP_SLT, 2'd1, 2'd2, 2'd3));
      place(imm_insn(isa_pkg::OP_STORE, 2'd0, 2'd1, 8'h88));
      place(reg_insn(isa_pkg::OP_SLT, 2'd1, 2'd3, 2'd2));
      place(imm_insn(isa_pkg::OP_STORE, 2'd0, 2'd1, 8'h89));
      // taken forward branches skip the stores between them
      place(imm_insn(isa_pkg::OP_BEQ, 2'd2, 2'd2, 8'd3));
      place(imm_insn(isa_pkg::OP_STORE, 2'd0, 2'd2, 8'h8A));
      place(imm_insn(isa_pkg::OP_STORE, 2'd0, 2'd3, 8'h8B));
      place(imm_insn(isa_pkg::OP_BNE, 2'd2, 2'd3, 8'd2));
      place(imm_insn(isa_pkg::OP_STORE, 2'd0, 2'd0, 8'h8C));
      place(imm_insn(isa_pkg::OP_BEQ, 2'd2, 2'd3, 8'd5));
      // backward offset of -20 that must not be taken
      place(imm_insn(isa_pkg::OP_BNE, 2'd0, 2'd0, 8'hEC));
      // countdown loop closed by a taken backward BNE of -2
      place(imm_insn(isa_pkg::OP_LI, 2'd0, 2'd0, 8'd3));
      place(imm_insn(isa_pkg::OP_LI, 2'd1, 2'd0, 8'd1));
      place(imm_insn(isa_pkg::OP_LI, 2'd3, 2'd0, 8'd0));
      place(reg_insn(isa_pkg::OP_SUB, 2'd0, 2'd0, 2'd1));
      place(imm_insn(isa_pkg::OP_STORE, 2'd0, 2'd0, 8'h90));
      place(imm_insn(isa_pkg::OP_BNE, 2'd0, 2'd3, 8'hFE));
      place(imm_insn(isa_pkg::OP_STORE, 2'd0, 2'd0, 8'h91));
      // jumps one word past the end, which is the halt address
      place(imm_insn(isa_pkg::OP_BEQ, 2'd0, 2'd3, 8'd2));
   endtask

   // instruction-level model of the engine, fills the expected lists
   function automatic void run_model();
      logic [31:0]      rf [4];
      logic [ADR_W-1:0] pc;
      logic [ADR_W-1:0] next;
      isa_pkg::insn_u   w;
      logic [31:0]      a;
      logic [31:0]      b;
      logic [31:0]      imm_x;
      logic [7:0]       imm_raw;
      int               steps;
      for (int i = 0; i < 4; i++) begin
         rf[i] = 32'h0;
      end
      pc    = RST_PC;
      steps = 0;
      while (prog_hit(pc) === 1'b1 && steps < 1000) begin
         exp_fetch.push_back(pc);
         w       = imem[pc];
         a       = rf[w.r.rs1];
         b       = rf[w.r.rs2];
         imm_raw = w.b.imm;
         imm_x   = {{24{imm_raw[7]}}, imm_raw};
         next    = pc + 1'b1;
         case (w.r.opcode)
            isa_pkg::OP_ADD: rf[w.r.rd] = a + b;
            isa_pkg::OP_SUB: rf[w.r.rd] = a - b;
            isa_pkg::OP_AND: rf[w.r.rd] = a & b;
            isa_pkg::OP_XOR: rf[w.r.rd] = a ^ b;
            isa_pkg::OP_SLT: rf[w.r.rd] = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            isa_pkg::OP_LI:  rf[w.b.ra] = imm_x;
            isa_pkg::OP_BEQ: begin
               if (rf[w.b.ra] == rf[w.b.rb]) next = pc + imm_x[ADR_W-1:0];
            end
            isa_pkg::OP_BNE: begin
               if (rf[w.b.ra] != rf[w.b.rb]) next = pc + imm_x[ADR_W-1:0];
            end
            isa_pkg::OP_STORE: begin
               exp_st_adr.push_back(ADR_W'(imm_raw));
               exp_st_dat.push_back(rf[w.b.rb]);
            end
            default: ;
         endcase
         pc    = next;
         steps = steps + 1;
      end
      // the fetch outside the program is the last one the engine makes
      exp_fetch.push_back(pc);
   endfunction

   // instruction slave, acks one cycle after a random wait, never acks the halt address
   always @(negedge clk) begin
      if (rst) begin
         ibus_ack  = 1'b0;
         ibus_wait = 1'b0;
      end else if (ibus_ack) begin
         ibus_ack = 1'b0;
         ibus_dat = 32'h0;
      end else if (ibus_cyc && ibus_stb && prog_hit(ibus_adr) === 1'b1) begin
         if (!ibus_wait) begin
            ibus_wait  = 1'b1;
            ibus_delay = $random(seed) & 3;
         end
         if (ibus_delay == 0) begin
            ibus_ack  = 1'b1;
            ibus_dat  = imem[ibus_adr];
            ibus_wait = 1'b0;
         end else begin
            ibus_delay = ibus_delay - 1;
         end
      end
   end

   // data slave takes every write after a random wait
   always @(negedge clk) begin
      if (rst) begin
         dbus_ack  = 1'b0;
         dbus_wait = 1'b0;
      end else if (dbus_ack) begin
         dbus_ack = 1'b0;
      end else if (dbus_cyc && dbus_stb) begin
         if (!dbus_wait) begin
            dbus_wait  = 1'b1;
            dbus_delay = $random(seed) & 3;
         end
         if (dbus_delay == 0) begin
            dbus_ack  = 1'b1;
            dbus_wait = 1'b0;
         end else begin
            dbus_delay = dbus_delay - 1;
         end
      end
   end

   // compares bus activity at the rising edge, where the slave sees it
   always @(posedge clk) begin
      if (!rst) begin
         check_value(ibus_stb, ibus_cyc, "ibus stb differs from cyc");
         check_value(dbus_stb, dbus_cyc, "dbus stb differs from cyc");
         if (ibus_cyc === 1'b1) begin
            if (!ibus_open) begin
               ibus_open     = 1'b1;
               ibus_adr_hold = ibus_adr;
               if (fetch_idx < exp_fetch.size()) begin
                  check_value(ibus_adr, exp_fetch[fetch_idx],
                              $sformatf("fetch %0d address", fetch_idx));
               end else begin
                  other_err = other_err + 1;
                  $display("fetch at address %h came after the expected list ended",
                           ibus_adr);
               end
               fetch_idx = fetch_idx + 1;
               if (prog_hit(ibus_adr) === 1'b0) halted = 1'b1;
            end else begin
               check_value(ibus_adr, ibus_adr_hold, "ibus address changed before ack");
            end
            if (ibus_ack) ibus_open = 1'b0;
         end
         if (dbus_cyc === 1'b1) begin
            if (!dbus_open) begin
               dbus_open     = 1'b1;
               dbus_adr_hold = dbus_adr;
               dbus_dat_hold = dbus_dat;
            end else begin
               check_value(dbus_adr, dbus_adr_hold, "dbus address changed before ack");
               check_value(dbus_dat, dbus_dat_hold, "dbus data changed before ack");
            end
            // a store counts once the slave takes it
            if (dbus_ack) begin
               dbus_open = 1'b0;
               if (store_idx < exp_st_adr.size()) begin
                  check_value(dbus_adr, exp_st_adr[store_idx],
                              $sformatf("store %0d address", store_idx));
                  check_value(dbus_dat, exp_st_dat[store_idx],
                              $sformatf("store %0d data", store_idx));
               end else begin
                  other_err = other_err + 1;
                  $display("store to address %h came after the expected list ended",
                           dbus_adr);
               end
               store_idx = store_idx + 1;
            end
         end
      end
   end

   initial begin
      seed     = 32'h55d2;
      rst      = 1'b1;
      ibus_dat = 32'h0;
      ibus_ack = 1'b0;
      dbus_ack = 1'b0;
      build_program();
      run_model();
      limit = exp_fetch.size() * CYC_PER_INSN + 100;
      // both buses stay idle for the two reset cycles
      repeat (2) begin
         @(posedge clk);
         @(negedge clk);
         check_value(ibus_cyc, 1'b0, "ibus cyc during reset");
         check_value(ibus_stb, 1'b0, "ibus stb during reset");
         check_value(dbus_cyc, 1'b0, "dbus cyc during reset");
         check_value(dbus_stb, 1'b0, "dbus stb during reset");
      end
      rst = 1'b0;
      while (!halted && cycles < limit) begin
         @(posedge clk);
         cycles = cycles + 1;
      end
      repeat (4) @(negedge clk);
      if (!halted) begin
         other_err = other_err + 1;
         $display("timed out after %0d cycles without reaching the halt address", cycles);
      end
      if (fetch_idx < exp_fetch.size()) begin
         other_err = other_err + 1;
         $display("only %0d of %0d expected fetches were seen", fetch_idx, exp_fetch.size());
      end
      if (store_idx < exp_st_adr.size()) begin
         other_err = other_err + 1;
         $display("only %0d of %0d expected stores were seen", store_idx, exp_st_adr.size());
      end
      $display("tb_bsc: %0d fetches, %0d stores, %0d value errors, %0d other errors",
               fetch_idx, store_idx, val_err, other_err);
      if (val_err == 0 && other_err == 0) begin
         $display("Simulation completed successfully");
      end else begin
         $display("Simulation failed");
      end
      $finish;
   end

endmodule

/* verilog/bsc_decode.sv */
`include "bsc_cfg.svh"

module bsc_decode (
   input  logic                     i_clk,
   input  logic                     i_rst,
   input  logic                     i_ibus_ack,
   input  logic [31:0]              i_ibus_dat,
   output logic                     o_two_stage,
   output logic                     o_mem_op,
   output logic                     o_br_op,
   output logic                     o_br_ne,
   output ctrl_pkg::alu_op_e        o_alu_op,
   output ctrl_pkg::wsrc_e          o_wsrc,
   output logic                     o_rd_we,
   output isa_pkg::reg_idx_t        o_rd,
   output isa_pkg::reg_idx_t        o_rs1,
   output isa_pkg::reg_idx_t        o_rs2,
   output logic [7:0]               o_imm,
   output logic [`BSC_ADR_W-1:0]    o_dbus_adr
);

   localparam int ADR_W = `BSC_ADR_W;

   isa_pkg::insn_u insn_q;
   isa_pkg::insn_u insn_cur;

   // the instruction register loads on the fetch ack
   always_ff @(posedge i_clk) begin
      if (i_rst) begin
         insn_q <= '0;
      end else if (i_ibus_ack) begin
         insn_q <= i_ibus_dat;
      end
   end

   // during the ack cycle the incoming word is decoded straight from the bus
   // so the sequencer can pick the next state on the ack edge
   always_comb begin
      if (i_ibus_ack) begin
         insn_cur = i_ibus_dat;
      end else begin
         insn_cur = insn_q;
      end
   end

   // the immediate view is the same bits for every opcode, only its use differs
   assign o_imm      = insn_cur.b.imm;
   assign o_dbus_adr = ADR_W'(unsigned'(insn_cur.b.imm));

   always_comb begin
      o_two_stage = 1'b0;
      o_mem_op    = 1'b0;
      o_br_op     = 1'b0;
      o_br_ne     = 1'b0;
      o_alu_op    = ctrl_pkg::ALU_ADD;
      o_wsrc      = ctrl_pkg::WS_ALU;
      o_rd_we     = 1'b0;
      o_rd        = insn_cur.r.rd;
      o_rs1       = insn_cur.r.rs1;
      o_rs2       = insn_cur.r.rs2;
      case (insn_cur.r.opcode)
         isa_pkg::OP_ADD: begin
            o_rd_we = 1'b1;
         end
         isa_pkg::OP_SUB: begin
            o_alu_op = ctrl_pkg::ALU_SUB;
            o_rd_we  = 1'b1;
         end
         isa_pkg::OP_AND: begin
            o_alu_op = ctrl_pkg::ALU_AND;
            o_rd_we  = 1'b1;
         end
         isa_pkg::OP_XOR: begin
            o_alu_op = ctrl_pkg::ALU_XOR;
            o_rd_we  = 1'b1;
         end
         // first pass subtracts for the signed compare, second pass writes it
         isa_pkg::OP_SLT: begin
            o_two_stage = 1'b1;
            o_alu_op    = ctrl_pkg::ALU_SUB;
            o_wsrc      = ctrl_pkg::WS_CMP;
            o_rd_we     = 1'b1;
         end
         // ra of the immediate view lies on the rd bits of the register view
         isa_pkg::OP_LI: begin
            o_wsrc  = ctrl_pkg::WS_IMM;
            o_rd_we = 1'b1;
         end
         // branches compare ra and rb bitwise, XOR feeds the not-equal flag
         isa_pkg::OP_BEQ, isa_pkg::OP_BNE: begin
            o_two_stage = 1'b1;
            o_br_op     = 1'b1;
            o_br_ne     = (insn_cur.r.opcode == isa_pkg::OP_BNE);
            o_alu_op    = ctrl_pkg::ALU_XOR;
            o_rs1       = insn_cur.b.ra;
            o_rs2       = insn_cur.b.rb;
         end
         // store data comes from rb through the parallel register tap
         isa_pkg::OP_STORE: begin
            o_mem_op = 1'b1;
            o_rs2    = insn_cur.b.rb;
         end
         // anything else just steps the PC
         default: begin
            o_rd_we = 1'b0;
         end
      endcase
   end

endmodule

/* verilog/bsc_top.sv */
`include "bsc_cfg.svh"

module bsc_top (
   input  logic                  i_clk,
   input  logic                  i_rst,
   // instruction bus, Wishbone classic read-only master
   output logic                  o_ibus_cyc,
   output logic                  o_ibus_stb,
   output logic [`BSC_ADR_W-1:0] o_ibus_adr,
   input  logic [31:0]           i_ibus_dat,
   input  logic                  i_ibus_ack,
   // data bus, Wishbone classic write-only master
   output logic                  o_dbus_cyc,
   output logic                  o_dbus_stb,
   output logic [`BSC_ADR_W-1:0] o_dbus_adr,
   output logic [31:0]           o_dbus_dat,
   input  logic                  i_dbus_ack
);

   // class flags and datapath controls from the decoder
   logic               two_stage;
   logic               mem_op;
   logic               br_op;
   logic               br_ne;
   ctrl_pkg::alu_op_e  alu_op;
   ctrl_pkg::wsrc_e    wsrc;
   logic               rd_we;
   isa_pkg::reg_idx_t  rd;
   isa_pkg::reg_idx_t  rs1;
   isa_pkg::reg_idx_t  rs2;
   logic [7:0]         imm;

   // pass pacing between the sequencer and the bit counter
   logic               start_pass;
   logic               init;
   logic               cnt_en;
   logic               cnt0;
   logic               cnt_last;
   logic               cnt_done;

   // serial operand and result bits
   logic               op_a;
   logic               op_b;
   logic               alu_res;
   logic               cmp;

   bsc_state u_state (
      .i_clk        (i_clk),
      .i_rst        (i_rst),
      .i_ibus_ack   (i_ibus_ack),
      .i_dbus_ack   (i_dbus_ack),
      .i_two_stage  (two_stage),
      .i_mem_op     (mem_op),
      .i_cnt_done   (cnt_done),
      .o_ibus_cyc   (o_ibus_cyc),
      .o_ibus_stb   (o_ibus_stb),
      .o_dbus_cyc   (o_dbus_cyc),
      .o_dbus_stb   (o_dbus_stb),
      .o_start_pass (start_pass),
      .o_init       (init)
   );

   bsc_count u_count (
      .i_clk        (i_clk),
      .i_rst        (i_rst),
      .i_start_pass (start_pass),
      .o_cnt_en     (cnt_en),
      .o_cnt0       (cnt0),
      .o_cnt_last   (cnt_last),
      .o_cnt_done   (cnt_done)
   );

   bsc_decode u_decode (
      .i_clk       (i_clk),
      .i_rst       (i_rst),
      .i_ibus_ack  (i_ibus_ack),
      .i_ibus_dat  (i_ibus_dat),
      .o_two_stage (two_stage),
      .o_mem_op    (mem_op),
      .o_br_op     (br_op),
      .o_br_ne     (br_ne),
      .o_alu_op    (alu_op),
      .o_wsrc      (wsrc),
      .o_rd_we     (rd_we),
      .o_rd        (rd),
      .o_rs1       (rs1),
      .o_rs2       (rs2),
      .o_imm       (imm),
      .o_dbus_adr  (o_dbus_adr)
   );

   bsc_alu u_alu (
      .i_clk      (i_clk),
      .i_rst      (i_rst),
      .i_cnt_en   (cnt_en),
      .i_cnt0     (cnt0),
      .i_cnt_last (cnt_last),
      .i_init     (init),
      .i_alu_op   (alu_op),
      .i_op_a     (op_a),
      .i_op_b     (op_b),
      .o_res      (alu_res),
      .o_cmp      (cmp)
   );

   bsc_regs u_regs (
      .i_clk      (i_clk),
      .i_rst      (i_rst),
      .i_cnt_en   (cnt_en),
      .i_cnt0     (cnt0),
      .i_init     (init),
      .i_rd_we    (rd_we),
      .i_rd       (rd),
      .i_rs1      (rs1),
      .i_rs2      (rs2),
      .i_wsrc     (wsrc),
      .i_imm      (imm),
      .i_br_op    (br_op),
      .i_br_ne    (br_ne),
      .i_cmp      (cmp),
      .i_alu_res  (alu_res),
      .o_op_a     (op_a),
      .o_op_b     (op_b),
      .o_ibus_adr (o_ibus_adr),
      .o_dbus_dat (o_dbus_dat)
   );

endmodule
